// File: riscv_consts.svh
// RV64I core constants.
// Widths, reset PC, opcode and funct3 encodings.
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

`define XLEN            64
`define INSTR_WIDTH     32
`define OUT_ADDR_WIDTH  32
`define REG_ADDR_WIDTH  5
`define RESET_PC        32'h8000_0000

// Major opcodes.
`define OP_LUI          7'b0110111
`define OP_OP           7'b0110011
`define OP_OP_IMM       7'b0010011
`define OP_LOAD         7'b0000011
`define OP_STORE        7'b0100011

// Funct3 codes for OP and OP-IMM.
`define F3_ADD_SUB      3'b000
`define F3_SLL          3'b001
`define F3_SLT          3'b010
`define F3_SLTU         3'b011
`define F3_XOR          3'b100
`define F3_SRL_SRA      3'b101
`define F3_OR           3'b110
`define F3_AND          3'b111

// Doubleword access size for LD and SD.
`define F3_DOUBLE       3'b011

`endif

// File: riscv_pkg.sv
// RV64I core shared types.
// Data words, addresses and the control select encodings.
`include "riscv_consts.svh"

package riscv_pkg;

    typedef logic [`XLEN-1:0]           xlen_t;
    typedef logic [`INSTR_WIDTH-1:0]    instr_t;
    typedef logic [`OUT_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // ALU operations.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // First ALU operand.
    typedef enum logic [1:0] {
        SRC_A_PC,
        SRC_A_OLD_PC,
        SRC_A_RS1,
        SRC_A_ZERO
    } alu_src_a_e;

    // Second ALU operand.
    typedef enum logic [1:0] {
        SRC_B_RS2,
        SRC_B_IMM,
        SRC_B_FOUR
    } alu_src_b_e;

    // Value written to the PC or the register file.
    typedef enum logic [1:0] {
        RES_ALU_REG,
        RES_MEM_DATA,
        RES_ALU
    } result_src_e;

    // Immediate forms.
    typedef enum logic [1:0] {
        IMM_I,
        IMM_S,
        IMM_U
    } imm_src_e;

endpackage

// File: core_ctrl_if.sv
// Controller to datapath bus.
// Carries enables and selects one way, decoded instruction fields back.
`timescale 1ns/1ps

interface core_ctrl_if;
    import riscv_pkg::*;

    // Write enables.
    logic        pc_we;
    logic        instr_we;
    logic        reg_we;
    logic        mem_data_we;

    // Datapath selects.
    alu_op_e     alu_op;
    alu_src_a_e  alu_src_a;
    alu_src_b_e  alu_src_b;
    result_src_e result_src;
    imm_src_e    imm_src;
    logic        addr_sel;

    // Fields of the instruction register.
    logic [6:0]  op;
    logic [2:0]  funct3;
    logic        funct7_5;

    modport controller (
        output pc_we, instr_we, reg_we, mem_data_we,
        output alu_op, alu_src_a, alu_src_b, result_src, imm_src, addr_sel,
        input  op, funct3, funct7_5
    );

    modport datapath (
        input  pc_we, instr_we, reg_we, mem_data_we,
        input  alu_op, alu_src_a, alu_src_b, result_src, imm_src, addr_sel,
        output op, funct3, funct7_5
    );

endinterface

// File: alu.sv
// 64-bit integer ALU.
// Add, subtract, shifts, compares and bitwise logic for RV64I.
`timescale 1ns/1ps
`include "riscv_consts.svh"

module alu (
    input  riscv_pkg::alu_op_e i_alu_op,
    input  riscv_pkg::xlen_t   i_src_1,
    input  riscv_pkg::xlen_t   i_src_2,
    output riscv_pkg::xlen_t   o_result
);
    import riscv_pkg::*;

    localparam int SHAMT_WIDTH = $clog2(`XLEN);

    logic [SHAMT_WIDTH-1:0] s_shamt;

    // Only the low six bits count as the shift amount.
    assign s_shamt = i_src_2[SHAMT_WIDTH-1:0];

    always_comb begin
        case (i_alu_op)
            ALU_ADD:  o_result = i_src_1 + i_src_2;
            ALU_SUB:  o_result = i_src_1 - i_src_2;
            ALU_SLL:  o_result = i_src_1 << s_shamt;
            ALU_SLT:  o_result = xlen_t'($signed(i_src_1) < $signed(i_src_2));
            ALU_SLTU: o_result = xlen_t'(i_src_1 < i_src_2);
            ALU_XOR:  o_result = i_src_1 ^ i_src_2;
            ALU_SRL:  o_result = i_src_1 >> s_shamt;
            ALU_SRA:  o_result = xlen_t'($signed(i_src_1) >>> s_shamt);
            ALU_OR:   o_result = i_src_1 | i_src_2;
            ALU_AND:  o_result = i_src_1 & i_src_2;
            default:  o_result = '0;
        endcase
    end

endmodule

// File: register_file.sv
// Integer register file, 32 x 64 bits.
// Two combinational read ports, one clocked write port, x0 reads as zero.
`timescale 1ns/1ps
`include "riscv_consts.svh"

module register_file (
    input  logic                 clk,
    input  logic                 i_we,
    input  riscv_pkg::reg_addr_t i_addr_1,
    input  riscv_pkg::reg_addr_t i_addr_2,
    input  riscv_pkg::reg_addr_t i_addr_3,
    input  riscv_pkg::xlen_t     i_write_data,
    output riscv_pkg::xlen_t     o_read_data_1,
    output riscv_pkg::xlen_t     o_read_data_2
);
    import riscv_pkg::*;

    xlen_t s_regs [2**`REG_ADDR_WIDTH];

    // Write port, x0 stays untouched.
    always_ff @(posedge clk) begin
        if (i_we && (i_addr_3 != '0)) begin
            s_regs[i_addr_3] <= i_write_data;
        end
    end

    assign o_read_data_1 = (i_addr_1 == '0) ? '0 : s_regs[i_addr_1];
    assign o_read_data_2 = (i_addr_2 == '0) ? '0 : s_regs[i_addr_2];

endmodule

// File: extend_imm.sv
// Immediate generator.
// Builds sign-extended I, S and U immediates from the instruction.
`timescale 1ns/1ps
`include "riscv_consts.svh"

module extend_imm (
    input  riscv_pkg::imm_src_e i_imm_src,
    input  riscv_pkg::instr_t   i_instr,
    output riscv_pkg::xlen_t    o_imm_ext
);
    import riscv_pkg::*;

    always_comb begin
        case (i_imm_src)
            IMM_I:   o_imm_ext = {{(`XLEN-12){i_instr[31]}}, i_instr[31:20]};
            IMM_S:   o_imm_ext = {{(`XLEN-12){i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            // Upper 20 bits, then sign from bit 31.
            IMM_U:   o_imm_ext = {{(`XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};
            default: o_imm_ext = '0;
        endcase
    end

endmodule

// File: control_unit.sv
// Multicycle control unit.
// FSM and decoder for the datapath selects and the memory start pulses.
`timescale 1ns/1ps
`include "riscv_consts.svh"

module control_unit (
    input  logic clk,
    input  logic i_rst,
    input  logic i_done,
    output logic o_start_fetch,
    output logic o_start_read_nc,
    output logic o_start_write_nc,
    core_ctrl_if.controller ctrl
);
    import riscv_pkg::*;

    typedef enum logic [2:0] {
        S_FETCH_ISSUE,
        S_FETCH_WAIT,
        S_DECODE,
        S_EXECUTE,
        S_MEM_ADDR,
        S_MEM_READ_WAIT,
        S_MEM_WRITE_WAIT,
        S_WRITEBACK
    } state_e;

    state_e     s_state;
    state_e     s_next_state;

    logic       s_is_alu;
    logic       s_is_load;
    logic       s_is_store;
    logic       s_shift_arith;

    alu_op_e    s_dec_alu_op;
    alu_src_a_e s_dec_src_a;
    alu_src_b_e s_dec_src_b;
    imm_src_e   s_dec_imm_src;

    // Maps funct3 to an ALU operation; alt picks sub or sra.
    function automatic alu_op_e funct_to_alu_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            `F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            `F3_SLL:     op = ALU_SLL;
            `F3_SLT:     op = ALU_SLT;
            `F3_SLTU:    op = ALU_SLTU;
            `F3_XOR:     op = ALU_XOR;
            `F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            `F3_OR:      op = ALU_OR;
            default:     op = ALU_AND;
        endcase
        return op;
    endfunction

    //------------------------------------------------------------
    // Instruction decode.
    //------------------------------------------------------------
    assign s_is_alu   = (ctrl.op == `OP_OP) || (ctrl.op == `OP_OP_IMM) || (ctrl.op == `OP_LUI);
    assign s_is_load  = (ctrl.op == `OP_LOAD) && (ctrl.funct3 == `F3_DOUBLE);
    assign s_is_store = (ctrl.op == `OP_STORE) && (ctrl.funct3 == `F3_DOUBLE);

    // OP-IMM only honours bit 30 for right shifts.
    assign s_shift_arith = (ctrl.funct3 == `F3_SRL_SRA) && ctrl.funct7_5;

    always_comb begin
        s_dec_alu_op  = ALU_ADD;
        s_dec_src_a   = SRC_A_RS1;
        s_dec_src_b   = SRC_B_IMM;
        s_dec_imm_src = IMM_I;
        case (ctrl.op)
            `OP_OP: begin
                s_dec_src_b  = SRC_B_RS2;
                s_dec_alu_op = funct_to_alu_op(ctrl.funct3, ctrl.funct7_5);
            end
            `OP_OP_IMM: s_dec_alu_op = funct_to_alu_op(ctrl.funct3, s_shift_arith);
            `OP_LUI: begin
                s_dec_src_a   = SRC_A_ZERO;
                s_dec_imm_src = IMM_U;
            end
            `OP_STORE: s_dec_imm_src = IMM_S;
            default: ;
        endcase
    end

    //------------------------------------------------------------
    // Next state and datapath control.
    //------------------------------------------------------------
    always_comb begin
        s_next_state     = s_state;
        ctrl.pc_we       = 1'b0;
        ctrl.instr_we    = 1'b0;
        ctrl.reg_we      = 1'b0;
        ctrl.mem_data_we = 1'b0;
        ctrl.alu_op      = s_dec_alu_op;
        ctrl.alu_src_a   = s_dec_src_a;
        ctrl.alu_src_b   = s_dec_src_b;
        ctrl.imm_src     = s_dec_imm_src;
        ctrl.result_src  = RES_ALU_REG;
        ctrl.addr_sel    = 1'b0;

        case (s_state)
            S_FETCH_ISSUE, S_FETCH_WAIT: begin
                // PC plus four on the live ALU output.
                ctrl.alu_op     = ALU_ADD;
                ctrl.alu_src_a  = SRC_A_PC;
                ctrl.alu_src_b  = SRC_B_FOUR;
                ctrl.result_src = RES_ALU;
                if (s_state == S_FETCH_ISSUE) begin
                    s_next_state = S_FETCH_WAIT;
                end else if (i_done) begin
                    ctrl.pc_we    = 1'b1;
                    ctrl.instr_we = 1'b1;
                    s_next_state  = S_DECODE;
                end
            end
            S_DECODE: begin
                if (s_is_alu) begin
                    s_next_state = S_EXECUTE;
                end else if (s_is_load || s_is_store) begin
                    s_next_state = S_MEM_ADDR;
                end else begin
                    s_next_state = S_FETCH_ISSUE;
                end
            end
            S_EXECUTE: s_next_state = S_WRITEBACK;
            S_MEM_ADDR: begin
                ctrl.addr_sel = 1'b1;
                s_next_state  = s_is_load ? S_MEM_READ_WAIT : S_MEM_WRITE_WAIT;
            end
            S_MEM_READ_WAIT: begin
                ctrl.addr_sel = 1'b1;
                if (i_done) begin
                    ctrl.mem_data_we = 1'b1;
                    s_next_state     = S_WRITEBACK;
                end
            end
            S_MEM_WRITE_WAIT: begin
                ctrl.addr_sel = 1'b1;
                if (i_done) begin
                    s_next_state = S_FETCH_ISSUE;
                end
            end
            S_WRITEBACK: begin
                ctrl.reg_we     = 1'b1;
                ctrl.result_src = s_is_load ? RES_MEM_DATA : RES_ALU_REG;
                s_next_state    = S_FETCH_ISSUE;
            end
            default: s_next_state = S_FETCH_ISSUE;
        endcase
    end

    // State register and registered start pulses.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            s_state          <= S_FETCH_ISSUE;
            o_start_fetch    <= 1'b0;
            o_start_read_nc  <= 1'b0;
            o_start_write_nc <= 1'b0;
        end else begin
            s_state          <= s_next_state;
            o_start_fetch    <= (s_state == S_FETCH_ISSUE);
            o_start_read_nc  <= (s_state == S_MEM_ADDR) && s_is_load;
            o_start_write_nc <= (s_state == S_MEM_ADDR) && s_is_store;
        end
    end

endmodule

// File: datapath.sv
// Multicycle datapath.
// Architectural and staging registers, register file, ALU and operand muxing.
`timescale 1ns/1ps
`include "riscv_consts.svh"

module datapath (
    input  logic              clk,
    input  logic              i_rst,
    input  riscv_pkg::instr_t i_instr,
    input  riscv_pkg::xlen_t  i_data_non_cacheable,
    output riscv_pkg::addr_t  o_fetch_addr,
    output riscv_pkg::addr_t  o_addr_non_cacheable,
    output riscv_pkg::xlen_t  o_data_non_cacheable,
    core_ctrl_if.datapath     ctrl
);
    import riscv_pkg::*;

    // Registered state.
    xlen_t  s_reg_pc;
    xlen_t  s_reg_old_pc;
    instr_t s_reg_instr;
    xlen_t  s_reg_data_1;
    xlen_t  s_reg_data_2;
    xlen_t  s_reg_alu_result;
    xlen_t  s_reg_mem_data;

    // Combinational nets.
    xlen_t  s_read_data_1;
    xlen_t  s_read_data_2;
    xlen_t  s_imm_ext;
    xlen_t  s_src_a;
    xlen_t  s_src_b;
    xlen_t  s_alu_result;
    xlen_t  s_result;
    addr_t  s_out_addr;

    assign ctrl.op       = s_reg_instr[6:0];
    assign ctrl.funct3   = s_reg_instr[14:12];
    assign ctrl.funct7_5 = s_reg_instr[30];

    //------------------------------------------------------------
    // Submodules.
    //------------------------------------------------------------
    register_file rf (
        .clk           ( clk                 ),
        .i_we          ( ctrl.reg_we         ),
        .i_addr_1      ( s_reg_instr[19:15]  ),
        .i_addr_2      ( s_reg_instr[24:20]  ),
        .i_addr_3      ( s_reg_instr[11:7]   ),
        .i_write_data  ( s_result            ),
        .o_read_data_1 ( s_read_data_1       ),
        .o_read_data_2 ( s_read_data_2       )
    );

    extend_imm imm_ext (
        .i_imm_src ( ctrl.imm_src ),
        .i_instr   ( s_reg_instr  ),
        .o_imm_ext ( s_imm_ext    )
    );

    alu alu_unit (
        .i_alu_op ( ctrl.alu_op  ),
        .i_src_1  ( s_src_a      ),
        .i_src_2  ( s_src_b      ),
        .o_result ( s_alu_result )
    );

    //------------------------------------------------------------
    // Operand and result selection.
    //------------------------------------------------------------
    always_comb begin
        case (ctrl.alu_src_a)
            SRC_A_PC:     s_src_a = s_reg_pc;
            SRC_A_OLD_PC: s_src_a = s_reg_old_pc;
            SRC_A_RS1:    s_src_a = s_reg_data_1;
            default:      s_src_a = '0;
        endcase

        case (ctrl.alu_src_b)
            SRC_B_RS2:  s_src_b = s_reg_data_2;
            SRC_B_IMM:  s_src_b = s_imm_ext;
            SRC_B_FOUR: s_src_b = xlen_t'(4);
            default:    s_src_b = '0;
        endcase

        case (ctrl.result_src)
            RES_MEM_DATA: s_result = s_reg_mem_data;
            RES_ALU:      s_result = s_alu_result;
            default:      s_result = s_reg_alu_result;
        endcase
    end

    // One address bus serves fetches and data accesses.
    assign s_out_addr = ctrl.addr_sel ? s_reg_alu_result[`OUT_ADDR_WIDTH-1:0]
                                      : s_reg_pc[`OUT_ADDR_WIDTH-1:0];

    assign o_fetch_addr         = s_out_addr;
    assign o_addr_non_cacheable = s_out_addr;
    assign o_data_non_cacheable = s_reg_data_2;

    //------------------------------------------------------------
    // Registers.
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            s_reg_pc <= xlen_t'(`RESET_PC);
        end else if (ctrl.pc_we) begin
            s_reg_pc <= s_result;
        end
    end

    // Instruction and its own PC are captured together.
    always_ff @(posedge clk) begin
        if (ctrl.instr_we) begin
            s_reg_instr  <= i_instr;
            s_reg_old_pc <= s_reg_pc;
        end
        if (ctrl.mem_data_we) begin
            s_reg_mem_data <= i_data_non_cacheable;
        end
    end

    // Staging registers load every cycle.
    always_ff @(posedge clk) begin
        s_reg_data_1     <= s_read_data_1;
        s_reg_data_2     <= s_read_data_2;
        s_reg_alu_result <= s_alu_result;
    end

endmodule

// File: riscv_core.sv
// RV64I multicycle core top level.
// Connects the control unit and the datapath over the control bus.
`timescale 1ns/1ps

module riscv_core (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_done,
    input  riscv_pkg::instr_t i_instr,
    input  riscv_pkg::xlen_t  i_data_non_cacheable,
    output logic              o_start_fetch,
    output riscv_pkg::addr_t  o_fetch_addr,
    output logic              o_start_read_nc,
    output logic              o_start_write_nc,
    output riscv_pkg::addr_t  o_addr_non_cacheable,
    output riscv_pkg::xlen_t  o_data_non_cacheable
);
    import riscv_pkg::*;

    core_ctrl_if ctrl_bus ();

    control_unit cu (
        .clk              ( clk              ),
        .i_rst            ( i_rst            ),
        .i_done           ( i_done           ),
        .o_start_fetch    ( o_start_fetch    ),
        .o_start_read_nc  ( o_start_read_nc  ),
        .o_start_write_nc ( o_start_write_nc ),
        .ctrl             ( ctrl_bus         )
    );

    datapath dp (
        .clk                  ( clk                  ),
        .i_rst                ( i_rst                ),
        .i_instr              ( i_instr              ),
        .i_data_non_cacheable ( i_data_non_cacheable ),
        .o_fetch_addr         ( o_fetch_addr         ),
        .o_addr_non_cacheable ( o_addr_non_cacheable ),
        .o_data_non_cacheable ( o_data_non_cacheable ),
        .ctrl                 ( ctrl_bus             )
    );

endmodule

// File: tb_riscv_core.sv
// Testbench for the RV64I multicycle core.
// Random program, variable-latency memory responder and a reference model.
`timescale 1ns/1ps
`include "riscv_consts.svh"

module tb_riscv_core;
    import riscv_pkg::*;

    localparam int PROG_LEN   = 200;
    localparam int CLK_PERIOD = 4;
    localparam int TIMEOUT_NS = (8 + PROG_LEN * 20) * CLK_PERIOD;

    logic   clk = 1'b0;
    logic   i_rst;
    logic   i_done;
    instr_t i_instr;
    xlen_t  i_data_non_cacheable;
    logic   o_start_fetch;
    addr_t  o_fetch_addr;
    logic   o_start_read_nc;
    logic   o_start_write_nc;
    addr_t  o_addr_non_cacheable;
    xlen_t  o_data_non_cacheable;

    integer     seed = 60956;
    instr_t     prog [PROG_LEN];
    logic [6:0] unknown_ops [6] = '{7'h0f, 7'h73, 7'h1b, 7'h63, 7'h6f, 7'h17};

    // Responder state.
    xlen_t  resp_mem [addr_t];
    logic   waiting;
    int     wait_cnt;
    int     req_kind;
    addr_t  req_addr;
    int     run_edges;

    // Expected address and store data while a request waits.
    addr_t  held_addr;
    xlen_t  held_data;

    // Reference model state.
    xlen_t  model_regs [32];
    xlen_t  model_mem [addr_t];
    addr_t  model_pc;
    instr_t cur_instr;
    logic   have_cur;
    int     data_pulses;
    int     retired;
    logic   run_complete;
    int     n_mismatch;
    int     n_other;

    riscv_core i_dut (
        .clk                  ( clk                  ),
        .i_rst                ( i_rst                ),
        .i_done               ( i_done               ),
        .i_instr              ( i_instr              ),
        .i_data_non_cacheable ( i_data_non_cacheable ),
        .o_start_fetch        ( o_start_fetch        ),
        .o_fetch_addr         ( o_fetch_addr         ),
        .o_start_read_nc      ( o_start_read_nc      ),
        .o_start_write_nc     ( o_start_write_nc     ),
        .o_addr_non_cacheable ( o_addr_non_cacheable ),
        .o_data_non_cacheable ( o_data_non_cacheable )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //------------------------------------------------------------
    // Helpers.
    //------------------------------------------------------------
    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Background data that differs for every address.
    function automatic xlen_t fill_word(input addr_t a);
        return {a, ~a} ^ 64'h5a5a_c3c3_0f0f_9696;
    endfunction

    function automatic instr_t fetch_word(input addr_t a);
        addr_t idx;
        idx = (a - `RESET_PC) >> 2;
        if (idx < PROG_LEN) begin
            return prog[idx];
        end
        // Past the program the memory returns addi x0, x0, 0.
        return {12'd0, 5'd0, `F3_ADD_SUB, 5'd0, `OP_OP_IMM};
    endfunction

    // One random instruction. Loads and stores use x31 as base, so it is never written.
    function automatic instr_t random_instr();
        logic [31:0] w;
        logic [4:0]  rd;
        logic [11:0] imm;
        logic [11:0] off;
        logic [2:0]  pick;
        int unsigned kind;
        w    = $random(seed);
        kind = rnd(20);
        pick = 3'(rnd(6));
        rd   = (w[11:7] == 5'd31) ? 5'd0 : w[11:7];
        imm  = w[31:20];
        off  = {imm[11:3], 3'b000};
        if (kind < 6) begin
            // Bit 30 only for sub and sra.
            return {1'b0, w[30] & (w[14:12] == `F3_ADD_SUB || w[14:12] == `F3_SRL_SRA),
                    5'b0, w[24:20], w[19:15], w[14:12], rd, `OP_OP};
        end
        if (kind < 12) begin
            if (w[14:12] == `F3_SLL) begin
                imm = {6'b0, imm[5:0]};
            end
            if (w[14:12] == `F3_SRL_SRA) begin
                imm = {1'b0, imm[10], 4'b0, imm[5:0]};
            end
            return {imm, w[19:15], w[14:12], rd, `OP_OP_IMM};
        end
        if (kind < 13) begin
            return {w[31:12], rd, `OP_LUI};
        end
        if (kind < 16) begin
            return {off, 5'd31, `F3_DOUBLE, rd, `OP_LOAD};
        end
        if (kind < 19) begin
            return {off[11:5], w[24:20], 5'd31, `F3_DOUBLE, off[4:0], `OP_STORE};
        end
        return {w[31:7], unknown_ops[pick]};
    endfunction

    task automatic build_program();
        for (int r = 1; r < 31; r++) begin
            prog[r - 1] = {12'($random(seed)), 5'd0, `F3_ADD_SUB, 5'(r), `OP_OP_IMM};
        end
        // Base pointer x31 is 0x2000 - 0x800 in the centre of the data window.
        prog[30] = {20'h00002, 5'd31, `OP_LUI};
        prog[31] = {12'h800, 5'd31, `F3_ADD_SUB, 5'd31, `OP_OP_IMM};
        for (int i = 32; i < PROG_LEN; i++) begin
            prog[i] = random_instr();
        end
    endtask

    //------------------------------------------------------------
    // Checks.
    //------------------------------------------------------------
    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            n_mismatch++;
            $display("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic check_data(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            n_mismatch++;
            $display("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic report_fault(input string msg);
        n_other++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // Address and store data stay put until done.
    task automatic check_hold();
        if (req_kind == 0) begin
            check_addr("o_fetch_addr", held_addr, o_fetch_addr);
        end else begin
            check_addr("o_addr_non_cacheable", held_addr, o_addr_non_cacheable);
        end
        if (req_kind == 2) begin
            check_data("o_data_non_cacheable", held_data, o_data_non_cacheable);
        end
    endtask

    //------------------------------------------------------------
    // Reference model with the RV64I rules.
    //------------------------------------------------------------
    function automatic xlen_t model_alu(input logic [2:0] f3, input logic alt,
                                        input xlen_t a, input xlen_t b);
        case (f3)
            `F3_ADD_SUB: return alt ? a - b : a + b;
            `F3_SLL:     return a << b[5:0];
            `F3_SLT:     return ($signed(a) < $signed(b)) ? xlen_t'(1) : '0;
            `F3_SLTU:    return (a < b) ? xlen_t'(1) : '0;
            `F3_XOR:     return a ^ b;
            `F3_SRL_SRA: begin
                if (alt) begin
                    return xlen_t'($signed(a) >>> b[5:0]);
                end
                return a >> b[5:0];
            end
            `F3_OR:      return a | b;
            default:     return a & b;
        endcase
    endfunction

    task automatic write_reg(input reg_addr_t rd, input xlen_t value);
        if (rd != '0) begin
            model_regs[rd] = value;
        end
    endtask

    task automatic retire(input instr_t ins);
        logic [2:0] f3;
        xlen_t      r1;
        xlen_t      r2;
        xlen_t      imm_i;
        xlen_t      imm_s;
        addr_t      ea;
        int         want;
        f3    = ins[14:12];
        r1    = model_regs[ins[19:15]];
        r2    = model_regs[ins[24:20]];
        imm_i = {{(`XLEN-12){ins[31]}}, ins[31:20]};
        imm_s = {{(`XLEN-12){ins[31]}}, ins[31:25], ins[11:7]};
        want  = 0;
        case (ins[6:0])
            `OP_OP:     write_reg(ins[11:7], model_alu(f3, ins[30], r1, r2));
            `OP_OP_IMM: write_reg(ins[11:7], model_alu(f3, (f3 == `F3_SRL_SRA) && ins[30],
                                                       r1, imm_i));
            `OP_LUI:    write_reg(ins[11:7], {{(`XLEN-32){ins[31]}}, ins[31:12], 12'b0});
            `OP_LOAD: begin
                ea = addr_t'(r1 + imm_i);
                write_reg(ins[11:7], model_mem.exists(ea) ? model_mem[ea] : fill_word(ea));
                want = 1;
            end
            `OP_STORE: begin
                model_mem[addr_t'(r1 + imm_s)] = r2;
                want = 1;
            end
            default: ;
        endcase
        if (data_pulses != want) begin
            report_fault($sformatf("instruction %h made %0d data accesses, expected %0d",
                                   ins, data_pulses, want));
        end
        retired++;
    endtask

    //------------------------------------------------------------
    // Request handling.
    //------------------------------------------------------------
    task automatic start_request(input int kind, input addr_t addr);
        waiting  = 1'b1;
        req_kind = kind;
        req_addr = addr;
        wait_cnt = 1 + int'(rnd(4));
    endtask

    task automatic respond();
        waiting = 1'b0;
        i_done <= 1'b1;
        if (req_kind == 0) begin
            i_instr <= fetch_word(req_addr);
        end else if (req_kind == 1) begin
            i_data_non_cacheable <= resp_mem.exists(req_addr) ? resp_mem[req_addr]
                                                               : fill_word(req_addr);
        end
    endtask

    task automatic on_fetch();
        if (!have_cur && run_edges != 2) begin
            report_fault("first fetch pulse not in the first cycle after reset");
        end
        if (have_cur) begin
            retire(cur_instr);
        end
        if (retired == PROG_LEN) begin
            run_complete = 1'b1;
        end
        held_addr = model_pc;
        check_addr("o_fetch_addr", held_addr, o_fetch_addr);
        cur_instr   = fetch_word(model_pc);
        model_pc    = model_pc + 4;
        have_cur    = 1'b1;
        data_pulses = 0;
        start_request(0, o_fetch_addr);
    endtask

    task automatic on_data(input logic is_write);
        xlen_t imm;
        imm = is_write ? {{(`XLEN-12){cur_instr[31]}}, cur_instr[31:25], cur_instr[11:7]}
                       : {{(`XLEN-12){cur_instr[31]}}, cur_instr[31:20]};
        held_addr = addr_t'(model_regs[cur_instr[19:15]] + imm);
        held_data = model_regs[cur_instr[24:20]];
        if (!have_cur || data_pulses != 0) begin
            report_fault("data access without a fetch before it");
        end else if (cur_instr[6:0] != (is_write ? `OP_STORE : `OP_LOAD)) begin
            report_fault($sformatf("wrong data access kind for instruction %h", cur_instr));
        end else begin
            check_addr("o_addr_non_cacheable", held_addr, o_addr_non_cacheable);
            if (is_write) begin
                check_data("o_data_non_cacheable", held_data, o_data_non_cacheable);
            end
        end
        data_pulses++;
        if (is_write) begin
            resp_mem[o_addr_non_cacheable] = o_data_non_cacheable;
        end
        start_request(is_write ? 2 : 1, o_addr_non_cacheable);
    endtask

    task automatic observe_starts();
        int n;
        n = int'(o_start_fetch) + int'(o_start_read_nc) + int'(o_start_write_nc);
        if (n > 1) begin
            report_fault("more than one start pulse in one cycle");
        end
        if (n > 0 && (waiting || i_done)) begin
            report_fault("start pulse while a request still waits for done");
        end
        if (o_start_fetch) begin
            on_fetch();
        end
        if (o_start_read_nc) begin
            on_data(1'b0);
        end
        if (o_start_write_nc) begin
            on_data(1'b1);
        end
    endtask

    // Outputs seen here hold their values from the cycle before the edge.
    always @(posedge clk) begin
        if (i_rst) begin
            if (o_start_fetch === 1'b1 || o_start_read_nc === 1'b1
                    || o_start_write_nc === 1'b1) begin
                report_fault("start pulse during reset");
            end
        end else begin
            run_edges++;
            if (waiting || i_done) begin
                check_hold();
            end
            observe_starts();
            // Response buses carry junk outside the done cycle.
            i_done               <= 1'b0;
            i_instr              <= instr_t'($random(seed));
            i_data_non_cacheable <= {$random(seed), $random(seed)};
            if (waiting) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    respond();
                end
            end
        end
    end

    //------------------------------------------------------------
    // Run control.
    //------------------------------------------------------------
    initial begin
        i_rst                = 1'b1;
        i_done               = 1'b0;
        i_instr              = '0;
        i_data_non_cacheable = '0;
        waiting      = 1'b0;
        wait_cnt     = 0;
        req_kind     = 0;
        req_addr     = '0;
        run_edges    = 0;
        held_addr    = '0;
        held_data    = '0;
        model_pc     = `RESET_PC;
        have_cur     = 1'b0;
        data_pulses  = 0;
        retired      = 0;
        run_complete = 1'b0;
        n_mismatch   = 0;
        n_other      = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        build_program();
        repeat (8) @(posedge clk);
        i_rst <= 1'b0;
    end

    initial begin
        wait (run_complete);
        $display("Retired %0d instructions: %0d mismatches, %0d other errors",
                 retired, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns: %0d of %0d retired, %0d mismatches, %0d other errors",
                 TIMEOUT_NS, retired, PROG_LEN, n_mismatch, n_other);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
riscv_pkg.sv
core_ctrl_if.sv
alu.sv
register_file.sv
extend_imm.sv
control_unit.sv
datapath.sv
riscv_core.sv
tb_riscv_core.sv

// File: Makefile
# Verilator build and run of the RV64I core testbench.
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -f sources.f --top-module tb_riscv_core -o tb_riscv_core
	./obj_dir/tb_riscv_core | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log
